//--- bt_header_params.svh
`ifndef BT_HEADER_PARAMS_SVH
`define BT_HEADER_PARAMS_SVH

// bit timing
`define BT_TICK_DIV 6

// access code sections, in bit times
`define BT_PREAMBLE_BITS 4
`define BT_SYNC_BITS 64
`define BT_AC_BITS 72

// coded header
`define BT_FEC_REP 3
`define BT_HDR_INFO 10
`define BT_HDR_BITS 54
`define BT_HEC_FIRST (`BT_AC_BITS + `BT_FEC_REP * `BT_HDR_INFO)
`define BT_PKT_LAST 125

// x^8+x^7+x^5+x^2+x+1 without the x^8 term
`define BT_HEC_POLY 8'hA7

// x^7+x^4+1 without the x^7 term
`define BT_WHITEN_POLY 7'h11

`endif

//--- bt_header_pkg.sv
`default_nettype none

package bt_header_pkg;

  // BR packet header, bit 0 goes on air first
  typedef struct packed {
    logic       seqn;
    logic       arqn;
    logic       flow;
    logic [3:0] pk_type;
    logic [2:0] lt_addr;  // lowest bits, sent first
  } pkt_header_t;

  // where the burst is, decoded from the bit counter
  typedef enum logic [2:0] {
    ph_idle,
    ph_preamble,
    ph_sync,
    ph_trailer,
    ph_header,
    ph_hec
  } link_phase_t;

  // HEC shift register contents
  typedef logic [7:0] hec_t;

  // what a receive burst reports back
  typedef struct packed {
    pkt_header_t hdr;
    logic        hec_good;   // remainder was zero
    logic        addressed;  // good HEC and our lt_addr or broadcast
    logic        is_null;
    logic        is_poll;
    logic        is_fhs;
  } rx_result_t;

endpackage

`default_nettype wire

//--- header_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "bt_header_params.svh"

module header_sequencer (
  input  wire                        clk_6M,
  input  wire                        rstz,
  input  wire                        tx_req,
  input  wire                        rx_req,
  output logic                       tx_ack,
  output logic                       rx_ack,
  output logic                       bit_tick,
  output logic [6:0]                 bit_index,
  output bt_header_pkg::link_phase_t phase,
  output logic                       triplet_done,
  output logic                       hdr_start,
  output logic                       encoding
);

  logic [2:0] tick_cnt;
  logic [1:0] trip_cnt;
  logic       active;
  logic       rx_wait;   // rx done, waiting one tick before ack
  logic       idle;
  logic       start_tx;
  logic       start_rx;
  logic       last_bit;
  logic       in_hdr;
  logic       tx_busy;
  logic       rx_busy;

  // free running 1 us strobe
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tick_cnt <= '0;
    else if (bit_tick)
      tick_cnt <= '0;
    else
      tick_cnt <= tick_cnt + 3'd1;
  end

  assign bit_tick = (tick_cnt == 3'(`BT_TICK_DIV - 1));

  // new burst only with both handshakes back to zero
  assign idle     = !active && !rx_wait && !tx_ack && !rx_ack;
  assign start_tx = bit_tick && idle && tx_req;
  assign start_rx = bit_tick && idle && rx_req && !tx_req;  // tx wins a tie
  assign last_bit = bit_tick && active && (bit_index == 7'(`BT_PKT_LAST));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      active    <= 1'b0;
      encoding  <= 1'b0;
      bit_index <= '0;
    end
    else if (start_tx)
    begin
      active    <= 1'b1;
      encoding  <= 1'b1;
      bit_index <= '0;
    end
    else if (start_rx)
    begin
      active    <= 1'b1;
      encoding  <= 1'b0;
      bit_index <= 7'(`BT_AC_BITS);  // correlator already consumed the access code
    end
    else if (last_bit)
    begin
      active    <= 1'b0;
      bit_index <= '0;
    end
    else if (active && bit_tick)
      bit_index <= bit_index + 7'd1;
  end

  // four-phase handshakes
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_ack  <= 1'b0;
      rx_ack  <= 1'b0;
      rx_wait <= 1'b0;
    end
    else
    begin
      if (last_bit && encoding)
        tx_ack <= 1'b1;
      else if (tx_ack && !tx_req)
        tx_ack <= 1'b0;

      if (last_bit && !encoding)
        rx_wait <= 1'b1;
      else if (rx_wait && bit_tick)
        rx_wait <= 1'b0;

      if (rx_wait && bit_tick)
        rx_ack <= 1'b1;  // field capture is long done by now
      else if (rx_ack && !rx_req)
        rx_ack <= 1'b0;
    end
  end

  always_comb
  begin
    if (!active)
      phase = bt_header_pkg::ph_idle;
    else if (bit_index < 7'(`BT_PREAMBLE_BITS))
      phase = bt_header_pkg::ph_preamble;
    else if (bit_index < 7'(`BT_PREAMBLE_BITS + `BT_SYNC_BITS))
      phase = bt_header_pkg::ph_sync;
    else if (bit_index < 7'(`BT_AC_BITS))
      phase = bt_header_pkg::ph_trailer;
    else if (bit_index < 7'(`BT_HEC_FIRST))
      phase = bt_header_pkg::ph_header;
    else
      phase = bt_header_pkg::ph_hec;
  end

  assign in_hdr = (phase == bt_header_pkg::ph_header) || (phase == bt_header_pkg::ph_hec);

  // position inside the current FEC triplet
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      trip_cnt <= '0;
    else if (!in_hdr)
      trip_cnt <= '0;
    else if (bit_tick)
      trip_cnt <= triplet_done ? 2'd0 : trip_cnt + 2'd1;
  end

  assign triplet_done = bit_tick && in_hdr && (trip_cnt == 2'(`BT_FEC_REP - 1));

  // seed LFSRs just before the first coded bit
  assign hdr_start = start_rx ||
                     (bit_tick && active && encoding && (bit_index == 7'(`BT_AC_BITS - 1)));

  assign tx_busy = (active && encoding) || tx_ack;
  assign rx_busy = (active && !encoding) || rx_wait || rx_ack;

  a_one_direction: assert property (@(posedge clk_6M) disable iff (!rstz)
    !(tx_busy && rx_busy))
    else $error("tx and rx bursts overlap");

  a_tx_ack_has_req: assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(tx_ack) |-> tx_req)
    else $error("tx_ack raised without tx_req");

  a_rx_ack_has_req: assert property (@(posedge clk_6M) disable iff (!rstz)
    $rose(rx_ack) |-> rx_req)
    else $error("rx_ack raised without rx_req");

endmodule

`default_nettype wire

//--- header_fec_hec.sv
`timescale 1ns/1ns
`default_nettype none
`include "bt_header_params.svh"

module header_fec_hec (
  input  wire                        clk_6M,
  input  wire                        rstz,
  input  wire                        bit_tick,
  input  wire bt_header_pkg::link_phase_t phase,
  input  wire                        triplet_done,
  input  wire                        hdr_start,
  input  wire                        encoding,
  input  wire [7:0]                  uap,
  input  wire [27:0]                 native_clk,
  input  wire                        hdr_bit_in,
  input  wire                        rx_bit,
  output logic                       coded_bit,
  output logic                       dec_bit,
  output logic                       dec_bit_valid,
  output bt_header_pkg::hec_t        hec_rem
);

  bt_header_pkg::hec_t hec_reg;
  bt_header_pkg::hec_t hec_next;
  logic [6:0]          whiten;
  logic [6:0]          whiten_next;
  logic [1:0]          samp_cnt;
  logic [1:0]          samp;       // first two samples of a triplet
  logic                in_hdr;
  logic                tx_info;
  logic                rx_vote;
  logic                rx_info;
  logic                info_bit;
  logic                hec_fb;

  assign in_hdr = (phase == bt_header_pkg::ph_header) || (phase == bt_header_pkg::ph_hec);

  // during HEC the register drains itself, MSB first
  assign tx_info   = (phase == bt_header_pkg::ph_hec) ? hec_reg[7] : hdr_bit_in;
  assign coded_bit = in_hdr && (tx_info ^ whiten[6]);  // held for all three repeats

  // 2 of 3 vote, third sample taken straight from the line
  assign rx_vote = (samp[0] & samp[1]) | (samp[0] & rx_bit) | (samp[1] & rx_bit);
  assign rx_info = rx_vote ^ whiten[6];

  assign info_bit = encoding ? tx_info : rx_info;

  // Galois form, so feeding the sent HEC back in clears the register
  assign hec_fb      = hec_reg[7] ^ info_bit;
  assign hec_next    = {hec_reg[6:0], 1'b0} ^ (hec_fb ? `BT_HEC_POLY : 8'h00);
  assign whiten_next = {whiten[5:0], 1'b0} ^ (whiten[6] ? `BT_WHITEN_POLY : 7'h00);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hec_reg <= '0;
      whiten  <= '0;
    end
    else if (hdr_start)
    begin
      hec_reg <= uap;
      whiten  <= {1'b1, native_clk[6:1]};
    end
    else if (triplet_done)
    begin
      hec_reg <= hec_next;   // one step per information bit
      whiten  <= whiten_next;
    end
  end

  assign hec_rem = hec_reg;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      samp_cnt <= '0;
    else if (hdr_start || !in_hdr)
      samp_cnt <= '0;
    else if (bit_tick)
      samp_cnt <= (samp_cnt == 2'(`BT_FEC_REP - 1)) ? 2'd0 : samp_cnt + 2'd1;
  end

  always_ff @(posedge clk_6M)
  begin
    if (bit_tick && in_hdr && !encoding && (samp_cnt != 2'(`BT_FEC_REP - 1)))
      samp[samp_cnt[0]] <= rx_bit;
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      dec_bit_valid <= 1'b0;
    else
      dec_bit_valid <= triplet_done && !encoding;
  end

  always_ff @(posedge clk_6M)
  begin
    if (triplet_done && !encoding)
      dec_bit <= rx_info;  // de-whitened, same value the HEC just took
  end

  // third sample must always close the triplet in the sequencer too
  a_samp_cnt_range: assert property (@(posedge clk_6M) disable iff (!rstz)
    (bit_tick && in_hdr && (samp_cnt == 2'(`BT_FEC_REP - 1))) |-> triplet_done)
    else $error("triplet sample count past 2");

  a_triplet_aligned: assert property (@(posedge clk_6M) disable iff (!rstz)
    triplet_done |-> samp_cnt == 2'(`BT_FEC_REP - 1))
    else $error("triplet_done out of step with sample count");

endmodule

`default_nettype wire

//--- header_field_codec.sv
`timescale 1ns/1ns
`default_nettype none
`include "bt_header_params.svh"

module header_field_codec (
  input  wire                         clk_6M,
  input  wire                         rstz,
  input  wire                         bit_tick,
  input  wire bt_header_pkg::link_phase_t phase,
  input  wire [6:0]                   bit_index,
  input  wire                         encoding,
  input  wire bt_header_pkg::pkt_header_t tx_hdr,
  input  wire [63:0]                  sync_word,
  input  wire [2:0]                   my_lt_addr,
  input  wire                         coded_bit,
  input  wire                         dec_bit,
  input  wire                         dec_bit_valid,
  input  wire bt_header_pkg::hec_t    hec_rem,
  output logic                        hdr_bit_in,
  output logic                        tx_bit,
  output bt_header_pkg::rx_result_t   rx_result
);

  logic [6:0]                 sync_pos;
  logic [6:0]                 hdr_pos;
  logic [6:0]                 info_idx;
  logic [4:0]                 dec_cnt;   // decoded info bits this burst
  logic [9:0]                 rx_shift;
  bt_header_pkg::pkt_header_t rx_hdr;
  logic                       last_dec;
  logic                       hec_ok;
  logic                       lt_match;

  assign sync_pos = bit_index - 7'(`BT_PREAMBLE_BITS);
  assign hdr_pos  = bit_index - 7'(`BT_AC_BITS);
  assign info_idx = hdr_pos / 7'(`BT_FEC_REP);  // which header bit the triplet carries

  // LSB first into the encoder, only meaningful in the header phase
  assign hdr_bit_in = encoding && (phase == bt_header_pkg::ph_header) &&
                      tx_hdr[info_idx[3:0]];

  always_comb
  begin
    if (!encoding)
      tx_bit = 1'b0;  // quiet while receiving or idle
    else
    begin
      case (phase)
        bt_header_pkg::ph_preamble:
          tx_bit = ~sync_word[0] ^ bit_index[0];
        bt_header_pkg::ph_sync:
          tx_bit = sync_word[sync_pos[5:0]];
        bt_header_pkg::ph_trailer:
          tx_bit = ~sync_word[63] ^ bit_index[0];  // bit 68 is even
        bt_header_pkg::ph_header,
        bt_header_pkg::ph_hec:
          tx_bit = coded_bit;
        default:
          tx_bit = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      dec_cnt <= '0;
    else if (dec_bit_valid)
      dec_cnt <= dec_cnt + 5'd1;
    else if (bit_tick && (phase == bt_header_pkg::ph_idle))
      dec_cnt <= '0;  // ready for the next burst
  end

  // header fields arrive LSB first, so shift in from the top
  always_ff @(posedge clk_6M)
  begin
    if (dec_bit_valid && (dec_cnt < 5'(`BT_HDR_INFO)))
      rx_shift <= {dec_bit, rx_shift[9:1]};
  end

  assign rx_hdr   = rx_shift;
  assign last_dec = dec_bit_valid && (dec_cnt == 5'(`BT_HDR_BITS / `BT_FEC_REP - 1));
  assign hec_ok   = (hec_rem == 8'h00);  // already includes the last HEC bit
  assign lt_match = (rx_hdr.lt_addr == my_lt_addr) || (rx_hdr.lt_addr == 3'd0);

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_result <= '0;
    else if (last_dec)
    begin
      rx_result.hdr       <= rx_hdr;
      rx_result.hec_good  <= hec_ok;
      rx_result.addressed <= hec_ok && lt_match;
      rx_result.is_null   <= (rx_hdr.pk_type == 4'd0);
      rx_result.is_poll   <= (rx_hdr.pk_type == 4'd1);
      rx_result.is_fhs    <= (rx_hdr.pk_type == 4'd2);
    end
  end

endmodule

`default_nettype wire

//--- packet_header_top.sv
`timescale 1ns/1ns
`default_nettype none

module packet_header_top (
  input  wire                             clk_6M,
  input  wire                             rstz,
  input  wire                             tx_req,
  output wire                             tx_ack,
  input  wire bt_header_pkg::pkt_header_t tx_hdr,
  input  wire [63:0]                      sync_word,
  input  wire                             rx_req,
  output wire                             rx_ack,
  input  wire                             rx_bit,
  output wire bt_header_pkg::rx_result_t  rx_result,
  input  wire [7:0]                       uap,
  input  wire [27:0]                      native_clk,
  input  wire [2:0]                       my_lt_addr,
  output wire                             bit_tick,
  output wire                             tx_bit
);

  wire bt_header_pkg::link_phase_t phase;
  wire [6:0]                       bit_index;
  wire                             triplet_done;
  wire                             hdr_start;
  wire                             encoding;
  wire                             hdr_bit_in;
  wire                             coded_bit;
  wire                             dec_bit;
  wire                             dec_bit_valid;
  wire bt_header_pkg::hec_t        hec_rem;

  header_sequencer u_seq (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .tx_req       (tx_req),
    .rx_req       (rx_req),
    .tx_ack       (tx_ack),
    .rx_ack       (rx_ack),
    .bit_tick     (bit_tick),
    .bit_index    (bit_index),
    .phase        (phase),
    .triplet_done (triplet_done),
    .hdr_start    (hdr_start),
    .encoding     (encoding)
  );

  header_fec_hec u_fec (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .bit_tick      (bit_tick),
    .phase         (phase),
    .triplet_done  (triplet_done),
    .hdr_start     (hdr_start),
    .encoding      (encoding),
    .uap           (uap),
    .native_clk    (native_clk),
    .hdr_bit_in    (hdr_bit_in),
    .rx_bit        (rx_bit),
    .coded_bit     (coded_bit),
    .dec_bit       (dec_bit),
    .dec_bit_valid (dec_bit_valid),
    .hec_rem       (hec_rem)
  );

  header_field_codec u_codec (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .bit_tick      (bit_tick),
    .phase         (phase),
    .bit_index     (bit_index),
    .encoding      (encoding),
    .tx_hdr        (tx_hdr),
    .sync_word     (sync_word),
    .my_lt_addr    (my_lt_addr),
    .coded_bit     (coded_bit),
    .dec_bit       (dec_bit),
    .dec_bit_valid (dec_bit_valid),
    .hec_rem       (hec_rem),
    .hdr_bit_in    (hdr_bit_in),
    .tx_bit        (tx_bit),
    .rx_result     (rx_result)
  );

endmodule

`default_nettype wire

//--- tb_packet_header.sv
`timescale 1ns/1ns
`default_nettype none
`include "bt_header_params.svh"

module tb_packet_header;

  logic                       clk_6M;
  logic                       rstz;
  logic                       tx_req;
  logic                       rx_req;
  logic                       rx_bit;
  bt_header_pkg::pkt_header_t tx_hdr;
  logic [63:0]                sync_word;
  logic [7:0]                 uap;
  logic [27:0]                native_clk;
  logic [2:0]                 my_lt_addr;
  wire                        tx_ack;
  wire                        rx_ack;
  wire                        bit_tick;
  wire                        tx_bit;
  wire bt_header_pkg::rx_result_t rx_result;

  integer seed;
  integer cycles;
  integer cycle_limit;
  integer tick_phase;  // cycles since the last bit_tick, -1 before the first

  // one entry per test row
  string                      names[$];
  bit                         dirs[$];     // 1 = transmit
  bt_header_pkg::pkt_header_t hdrs[$];
  logic [7:0]                 uaps[$];
  logic [27:0]                clks[$];
  logic [63:0]                syncs[$];
  logic [2:0]                 my_lts[$];
  logic [53:0]                flips[$];    // coded bits to invert on receive
  logic                       exp_good[$];
  logic                       exp_addr[$];

  packet_header_top u_dut (
    .clk_6M     (clk_6M),
    .rstz       (rstz),
    .tx_req     (tx_req),
    .tx_ack     (tx_ack),
    .tx_hdr     (tx_hdr),
    .sync_word  (sync_word),
    .rx_req     (rx_req),
    .rx_ack     (rx_ack),
    .rx_bit     (rx_bit),
    .rx_result  (rx_result),
    .uap        (uap),
    .native_clk (native_clk),
    .my_lt_addr (my_lt_addr),
    .bit_tick   (bit_tick),
    .tx_bit     (tx_bit)
  );

  always #20 clk_6M = ~clk_6M;

  always @(posedge clk_6M)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("sim failed");
      $fatal(1);
    end
  end

  // one bit time is six clk_6M cycles
  always @(negedge clk_6M)
  begin
    if (tick_phase >= 0)
    begin
      tick_phase = tick_phase + 1;
      check_bit("bit_tick period", tick_phase == `BT_TICK_DIV, bit_tick);
      if (tick_phase == `BT_TICK_DIV)
        tick_phase = 0;
    end
    else if (rstz === 1'b1 && bit_tick === 1'b1)
      tick_phase = 0;
  end

  function automatic bt_header_pkg::pkt_header_t make_header(input logic [2:0] lt,
      input logic [3:0] ptype, input logic flow, input logic arqn, input logic seqn);
    bt_header_pkg::pkt_header_t h;
    h.lt_addr = lt;
    h.pk_type = ptype;
    h.flow    = flow;
    h.arqn    = arqn;
    h.seqn    = seqn;
    return h;
  endfunction

  // one step of the HEC generator g(D) = D^8+D^7+D^5+D^2+D+1
  function automatic logic [7:0] hec_step(input logic [7:0] r, input logic b);
    logic fb;
    fb = r[7] ^ b;
    return {r[6:0], 1'b0} ^ ({8{fb}} & `BT_HEC_POLY);
  endfunction

  // whitening sequence x^7+x^4+1, output taken from the top stage
  function automatic logic [6:0] whiten_step(input logic [6:0] w);
    return {w[5:0], 1'b0} ^ ({7{w[6]}} & `BT_WHITEN_POLY);
  endfunction

  function automatic logic [53:0] encode_header(input bt_header_pkg::pkt_header_t hdr,
      input logic [7:0] u, input logic [27:0] nclk);
    logic [7:0]  r;
    logic [6:0]  w;
    logic [17:0] info;
    logic [53:0] s;
    int          i;
    r = u;
    for (i = 0; i < 10; i++)
    begin
      info[i] = hdr[i];
      r = hec_step(r, hdr[i]);
    end
    for (i = 0; i < 8; i++)
      info[10 + i] = r[7 - i];  // HEC goes out MSB first
    w = {1'b1, nclk[6:1]};
    for (i = 0; i < 18; i++)
    begin
      s[3 * i +: 3] = {3{info[i] ^ w[6]}};
      w = whiten_step(w);
    end
    return s;
  endfunction

  function automatic logic [125:0] expected_burst(input logic [63:0] sw,
      input bt_header_pkg::pkt_header_t hdr, input logic [7:0] u, input logic [27:0] nclk);
    logic [125:0] e;
    int           i;
    for (i = 0; i < 4; i++)
      e[i] = (i % 2 == 0) ? ~sw[0] : sw[0];
    for (i = 0; i < 64; i++)
      e[4 + i] = sw[i];
    for (i = 0; i < 4; i++)
      e[68 + i] = (i % 2 == 0) ? ~sw[63] : sw[63];
    e[125:72] = encode_header(hdr, u, nclk);
    return e;
  endfunction

  // majority vote, de-whiten, rerun the HEC over all 18 bits
  function automatic bt_header_pkg::rx_result_t decode_stream(input logic [53:0] s,
      input logic [7:0] u, input logic [27:0] nclk, input logic [2:0] my_lt);
    bt_header_pkg::rx_result_t res;
    logic [7:0]                r;
    logic [6:0]                w;
    logic [17:0]               info;
    logic                      v;
    int                        i;
    r = u;
    w = {1'b1, nclk[6:1]};
    for (i = 0; i < 18; i++)
    begin
      v = (s[3 * i] & s[3 * i + 1]) | (s[3 * i] & s[3 * i + 2]) | (s[3 * i + 1] & s[3 * i + 2]);
      info[i] = v ^ w[6];
      r = hec_step(r, info[i]);
      w = whiten_step(w);
    end
    res.hdr       = info[9:0];
    res.hec_good  = (r == 8'h00);
    res.addressed = res.hec_good && (res.hdr.lt_addr == my_lt || res.hdr.lt_addr == 3'd0);
    res.is_null   = (res.hdr.pk_type == 4'd0);
    res.is_poll   = (res.hdr.pk_type == 4'd1);
    res.is_fhs    = (res.hdr.pk_type == 4'd2);
    return res;
  endfunction

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_header(input string name, input bt_header_pkg::pkt_header_t exp,
      input bt_header_pkg::pkt_header_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_result(input string name, input bt_header_pkg::rx_result_t exp,
      input bt_header_pkg::rx_result_t act);
    if (act !== exp)
    begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic add_row(input string name, input bit is_tx,
      input bt_header_pkg::pkt_header_t hdr, input logic [7:0] u, input logic [27:0] nclk,
      input logic [63:0] sw, input logic [2:0] my_lt, input logic [53:0] flip,
      input logic good, input logic addr);
    names.push_back(name);
    dirs.push_back(is_tx);
    hdrs.push_back(hdr);
    uaps.push_back(u);
    clks.push_back(nclk);
    syncs.push_back(sw);
    my_lts.push_back(my_lt);
    flips.push_back(flip);
    exp_good.push_back(good);
    exp_addr.push_back(addr);
  endtask

  task automatic build_table();
    bt_header_pkg::pkt_header_t h;
    logic [31:0]                r0;
    logic [31:0]                r1;
    logic [31:0]                r2;
    int                         i;
    add_row("tx_basic", 1, make_header(3'd3, 4'h4, 1, 0, 1), 8'h47, 28'h0000035,
            64'h4e9c_a37b_1f02_d5e6, 3'd3, '0, 1, 1);
    add_row("tx_sync_ones", 1, make_header(3'd7, 4'h1, 0, 1, 0), 8'h00, 28'hffffffe,
            64'hf0e1_d2c3_b4a5_9687, 3'd7, '0, 1, 1);
    add_row("tx_zero_hdr", 1, make_header(3'd0, 4'h0, 0, 0, 0), 8'hff, 28'h0000000,
            64'h0123_4567_89ab_cdee, 3'd0, '0, 1, 1);
    add_row("rx_clean_null", 0, make_header(3'd2, 4'h0, 1, 1, 0), 8'h9e, 28'h1234567,
            '0, 3'd2, '0, 1, 1);
    add_row("rx_clean_poll", 0, make_header(3'd5, 4'h1, 0, 0, 1), 8'h3c, 28'h00000a2,
            '0, 3'd5, '0, 1, 1);
    add_row("rx_fhs_bcast", 0, make_header(3'd0, 4'h2, 1, 0, 0), 8'h5a, 28'h7ffff7f,
            '0, 3'd6, '0, 1, 1);
    add_row("rx_other_addr", 0, make_header(3'd4, 4'hb, 0, 1, 1), 8'hd1, 28'h0000019,
            '0, 3'd1, '0, 1, 0);
    add_row("rx_single_flips", 0, make_header(3'd1, 4'h3, 1, 1, 1), 8'h6b, 28'h00004c6,
            '0, 3'd1, (54'd1 << 0) | (54'd1 << 13) | (54'd1 << 29) | (54'd1 << 39) |
            (54'd1 << 53), 1, 1);
    add_row("rx_bad_triplet", 0, make_header(3'd1, 4'h3, 1, 1, 1), 8'h6b, 28'h00004c6,
            '0, 3'd1, 54'h7 << 15, 0, 0);
    add_row("rx_bad_hec", 0, make_header(3'd0, 4'h0, 0, 0, 0), 8'h11, 28'h000007e,
            '0, 3'd3, 54'h7 << 45, 0, 0);
    for (i = 0; i < 3; i++)
    begin
      r0 = $random(seed);
      r1 = $random(seed);
      r2 = $random(seed);
      h = r0[9:0];
      add_row($sformatf("tx_rand%0d", i), 1, h, r0[17:10], r1[27:0], {r1, r2}, h.lt_addr,
              '0, 1, 1);
      add_row($sformatf("rx_rand%0d", i), 0, h, r2[7:0], r2[31:4], '0, h.lt_addr, '0, 1, 1);
    end
  endtask

  task automatic wait_tick();
    do
      @(negedge clk_6M);
    while (bit_tick !== 1'b1);
  endtask

  task automatic load_inputs(input int k);
    @(posedge clk_6M);
    tx_hdr     <= hdrs[k];
    sync_word  <= syncs[k];
    uap        <= uaps[k];
    native_clk <= clks[k];
    my_lt_addr <= my_lts[k];
  endtask

  // ack must hold with req high, and nothing new may go out meanwhile
  task automatic hold_and_release(input string name, input bit is_tx);
    repeat (8)
    begin
      wait_tick();
      check_bit($sformatf("%s ack held", name), 1'b1, is_tx ? tx_ack : rx_ack);
      if (is_tx)
        check_bit($sformatf("%s line quiet", name), 1'b0, tx_bit);
    end
    @(posedge clk_6M);
    if (is_tx)
      tx_req <= 1'b0;
    else
      rx_req <= 1'b0;
    do
      @(negedge clk_6M);
    while (is_tx ? tx_ack : rx_ack);
  endtask

  task automatic run_tx(input int k);
    logic [125:0] exp;
    int           i;
    exp = expected_burst(syncs[k], hdrs[k], uaps[k], clks[k]);
    load_inputs(k);
    @(posedge clk_6M);
    tx_req <= 1'b1;
    wait_tick();  // burst starts right after this tick
    for (i = 0; i <= `BT_PKT_LAST; i++)
    begin
      wait_tick();
      check_bit($sformatf("%s tx bit %0d", names[k], i), exp[i], tx_bit);
    end
    do
      @(negedge clk_6M);
    while (!tx_ack);
    hold_and_release(names[k], 1'b1);
  endtask

  task automatic run_rx(input int k);
    bt_header_pkg::rx_result_t exp;
    logic [53:0]               s;
    int                        i;
    s = encode_header(hdrs[k], uaps[k], clks[k]) ^ flips[k];
    exp = decode_stream(s, uaps[k], clks[k], my_lts[k]);
    load_inputs(k);
    @(posedge clk_6M);
    rx_req <= 1'b1;
    wait_tick();
    @(posedge clk_6M);
    rx_bit <= s[0];
    for (i = 0; i < `BT_HDR_BITS; i++)
    begin
      wait_tick();
      @(posedge clk_6M);  // DUT samples bit i on this edge
      rx_bit <= (i < `BT_HDR_BITS - 1) ? s[i + 1] : 1'b0;
    end
    do
      @(negedge clk_6M);
    while (!rx_ack);
    check_result($sformatf("%s result", names[k]), exp, rx_result);
    check_bit($sformatf("%s hec_good", names[k]), exp_good[k], rx_result.hec_good);
    check_bit($sformatf("%s addressed", names[k]), exp_addr[k], rx_result.addressed);
    if (exp_good[k])
      check_header($sformatf("%s header", names[k]), hdrs[k], rx_result.hdr);
    hold_and_release(names[k], 1'b0);
    check_result($sformatf("%s result kept", names[k]), exp, rx_result);
  endtask

  initial
  begin
    clk_6M      = 1'b0;
    rstz        = 1'b0;
    tx_req      = 1'b0;
    rx_req      = 1'b0;
    rx_bit      = 1'b0;
    tx_hdr      = '0;
    sync_word   = '0;
    uap         = '0;
    native_clk  = '0;
    my_lt_addr  = '0;
    cycles      = 0;
    cycle_limit = 0;
    tick_phase  = -1;
    seed        = 32'hed38c44a;
    build_table();
    cycle_limit = names.size() * 140 * `BT_TICK_DIV * 2;
    repeat (4) @(posedge clk_6M);
    rstz <= 1'b1;
    @(negedge clk_6M);
    check_bit("reset tx_ack", 1'b0, tx_ack);
    check_bit("reset rx_ack", 1'b0, rx_ack);
    check_bit("reset tx_bit", 1'b0, tx_bit);
    for (int k = 0; k < names.size(); k++)
    begin
      if (dirs[k])
        run_tx(k);
      else
        run_rx(k);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
bt_header_pkg.sv
header_sequencer.sv
header_fec_hec.sv
header_field_codec.sv
packet_header_top.sv
tb_packet_header.sv
